//--- Bender.yml
package:
  name: tpu_uart_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/tpu_ctrl_pkg.sv
      - uart/uart_rx.sv
      - uart/uart_tx.sv
      - rtl/cmd_parser.sv
      - rtl/mlp_loader.sv
      - rtl/resp_sender.sv
      - rtl/uart_controller.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tb_uart_controller.sv

//--- common/tpu_ctrl_consts.svh
`ifndef TPU_CTRL_CONSTS_SVH
`define TPU_CTRL_CONSTS_SVH

// Serial bit period in clock cycles
`define UART_CLKS_PER_BIT 16

// Payload of the weight and activation write commands
`define CMD_PAYLOAD_BYTES 4

// Response lengths in bytes
`define RESULT_RESP_BYTES 4
`define STATUS_RESP_BYTES 1

`endif

//--- common/tpu_ctrl_pkg.sv
`include "tpu_ctrl_consts.svh"

package tpu_ctrl_pkg;

    // Host command opcodes
    typedef enum logic [7:0] {
        OP_WRITE_WEIGHT = 8'h01,
        OP_WRITE_ACT    = 8'h02,
        OP_EXECUTE      = 8'h03,
        OP_READ_RESULT  = 8'h04,
        OP_STATUS       = 8'h05
    } opcode_e;

    // Opcode plus payload, byte 0 in the low bits
    typedef struct packed {
        opcode_e                               opcode;
        logic [`CMD_PAYLOAD_BYTES-1:0][7:0]    payload;
    } cmd_frame_t;

    // Strobes and data toward the accelerator
    typedef struct packed {
        logic        push_col0;
        logic        push_col1;
        logic [7:0]  weight;
        logic        act_valid;
        logic [15:0] act_row;
        logic        start;
    } mlp_ctrl_t;

    // Accelerator status as seen by the responder
    typedef struct packed {
        logic [3:0]         state;
        logic [4:0]         cycle_cnt;
        logic signed [31:0] acc0;
    } mlp_status_t;

    typedef enum logic [1:0] {PS_WAIT_OP, PS_COLLECT, PS_OFFER} parser_state_e;
    typedef enum logic [1:0] {LS_IDLE, LS_WEIGHT, LS_ACT} loader_state_e;
    typedef enum logic {RS_IDLE, RS_SEND} resp_state_e;

endpackage

//--- rtl/cmd_parser.sv
`include "tpu_ctrl_consts.svh"

module cmd_parser (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [7:0]              rx_byte,
    input  logic                    rx_valid,
    output tpu_ctrl_pkg::cmd_frame_t frame,
    output logic                    load_valid,
    input  logic                    load_ready,
    output logic                    resp_valid,
    input  logic                    resp_ready
);

    import tpu_ctrl_pkg::*;

    localparam logic [1:0] LAST_BYTE = 2'(`CMD_PAYLOAD_BYTES - 1);

    parser_state_e state;
    logic [1:0]    byte_cnt;
    cmd_frame_t    frame_q;
    logic          to_resp;

    // Read and status frames go to the responder, the rest to the loader
    assign to_resp    = (frame_q.opcode == OP_READ_RESULT) || (frame_q.opcode == OP_STATUS);
    assign load_valid = (state == PS_OFFER) && !to_resp;
    assign resp_valid = (state == PS_OFFER) && to_resp;
    assign frame      = frame_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= PS_WAIT_OP;
            byte_cnt <= '0;
        end else begin
            case (state)
                PS_WAIT_OP: begin
                    if (rx_valid) begin
                        byte_cnt <= '0;
                        case (opcode_e'(rx_byte))
                            OP_WRITE_WEIGHT, OP_WRITE_ACT: state <= PS_COLLECT;
                            OP_EXECUTE, OP_READ_RESULT, OP_STATUS: state <= PS_OFFER;
                            // Unknown opcode, keep waiting
                            default: state <= PS_WAIT_OP;
                        endcase
                    end
                end
                PS_COLLECT: begin
                    if (rx_valid) begin
                        if (byte_cnt == LAST_BYTE) begin
                            state <= PS_OFFER;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                        end
                    end
                end
                PS_OFFER: begin
                    // Bytes arriving here are dropped
                    if ((load_valid && load_ready) || (resp_valid && resp_ready)) begin
                        state <= PS_WAIT_OP;
                    end
                end
                default: state <= PS_WAIT_OP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == PS_WAIT_OP) begin
            frame_q.opcode <= opcode_e'(rx_byte);
        end else if (rx_valid && state == PS_COLLECT) begin
            frame_q.payload[byte_cnt] <= rx_byte;
        end
    end

    a_one_consumer: assert property (
        @(posedge clk) disable iff (rst) !(load_valid && resp_valid)
    );

endmodule

//--- rtl/mlp_loader.sv
`include "tpu_ctrl_consts.svh"

module mlp_loader (
    input  logic                     clk,
    input  logic                     rst,
    input  tpu_ctrl_pkg::cmd_frame_t frame,
    input  logic                     load_valid,
    output logic                     load_ready,
    output tpu_ctrl_pkg::mlp_ctrl_t  mlp_ctrl,
    output logic                     weights_ready
);

    import tpu_ctrl_pkg::*;

    loader_state_e                      state;
    logic [1:0]                         step;
    logic [`CMD_PAYLOAD_BYTES-1:0][7:0] payload_q;
    logic                               push_col0;
    logic                               push_col1;
    logic                               act_valid;
    logic                               start;
    logic [7:0]                         weight_q;
    logic [15:0]                        act_row_q;

    assign load_ready = (state == LS_IDLE);

    assign mlp_ctrl.push_col0 = push_col0;
    assign mlp_ctrl.push_col1 = push_col1;
    assign mlp_ctrl.weight    = weight_q;
    assign mlp_ctrl.act_valid = act_valid;
    assign mlp_ctrl.act_row   = act_row_q;
    assign mlp_ctrl.start     = start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= LS_IDLE;
            step          <= '0;
            push_col0     <= 1'b0;
            push_col1     <= 1'b0;
            act_valid     <= 1'b0;
            start         <= 1'b0;
            weights_ready <= 1'b0;
        end else begin
            push_col0 <= 1'b0;
            push_col1 <= 1'b0;
            act_valid <= 1'b0;
            start     <= 1'b0;
            case (state)
                LS_IDLE: begin
                    if (load_valid && load_ready) begin
                        // First step issued right on acceptance
                        case (frame.opcode)
                            OP_WRITE_WEIGHT: begin
                                push_col0 <= 1'b1;
                                step      <= 2'd1;
                                state     <= LS_WEIGHT;
                            end
                            OP_WRITE_ACT: begin
                                act_valid <= 1'b1;
                                state     <= LS_ACT;
                            end
                            OP_EXECUTE: start <= 1'b1;
                            default: state <= LS_IDLE;
                        endcase
                    end
                end
                LS_WEIGHT: begin
                    // Odd bytes go to col1
                    push_col0 <= !step[0];
                    push_col1 <= step[0];
                    step      <= step + 2'd1;
                    if (step == 2'd3) begin
                        weights_ready <= 1'b1;
                        state         <= LS_IDLE;
                    end
                end
                LS_ACT: begin
                    act_valid <= 1'b1;
                    state     <= LS_IDLE;
                end
                default: state <= LS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid && load_ready) begin
            payload_q <= frame.payload;
            weight_q  <= frame.payload[0];
            act_row_q <= {frame.payload[1], frame.payload[0]};
        end else if (state == LS_WEIGHT) begin
            weight_q <= payload_q[step];
        end else if (state == LS_ACT) begin
            act_row_q <= {payload_q[3], payload_q[2]};
        end
    end

    a_one_column: assert property (
        @(posedge clk) disable iff (rst) !(push_col0 && push_col1)
    );

endmodule

//--- rtl/resp_sender.sv
`include "tpu_ctrl_consts.svh"

module resp_sender (
    input  logic                      clk,
    input  logic                      rst,
    input  tpu_ctrl_pkg::cmd_frame_t  frame,
    input  logic                      resp_valid,
    output logic                      resp_ready,
    input  tpu_ctrl_pkg::mlp_status_t mlp_status,
    output logic [7:0]                tx_byte,
    output logic                      tx_valid,
    input  logic                      tx_ready
);

    import tpu_ctrl_pkg::*;

    localparam int BUF_BITS = `RESULT_RESP_BYTES * 8;

    resp_state_e                        state;
    logic [1:0]                         byte_idx;
    logic [1:0]                         last_idx;
    logic [`RESULT_RESP_BYTES-1:0][7:0] resp_buf;

    assign resp_ready = (state == RS_IDLE);
    assign tx_valid   = (state == RS_SEND);
    assign tx_byte    = resp_buf[byte_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RS_IDLE;
            byte_idx <= '0;
            last_idx <= '0;
        end else begin
            case (state)
                RS_IDLE: begin
                    if (resp_valid && resp_ready) begin
                        byte_idx <= '0;
                        if (frame.opcode == OP_READ_RESULT) begin
                            last_idx <= 2'(`RESULT_RESP_BYTES - 1);
                        end else begin
                            last_idx <= 2'(`STATUS_RESP_BYTES - 1);
                        end
                        state <= RS_SEND;
                    end
                end
                RS_SEND: begin
                    // One byte per transmitter handshake
                    if (tx_valid && tx_ready) begin
                        if (byte_idx == last_idx) begin
                            state <= RS_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 2'd1;
                        end
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

    // Snapshot of the status when the frame is taken
    always_ff @(posedge clk) begin
        if (resp_valid && resp_ready) begin
            if (frame.opcode == OP_READ_RESULT) begin
                resp_buf <= mlp_status.acc0;
            end else begin
                resp_buf <= {{(BUF_BITS - 8){1'b0}}, mlp_status.state[2:0],
                             mlp_status.cycle_cnt};
            end
        end
    end

endmodule

//--- rtl/uart_controller.sv
module uart_controller (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      uart_rx,
    output logic                      uart_tx,
    output tpu_ctrl_pkg::mlp_ctrl_t   mlp_ctrl,
    output logic                      weights_ready,
    input  tpu_ctrl_pkg::mlp_status_t mlp_status
);

    import tpu_ctrl_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    cmd_frame_t frame;
    logic       load_valid;
    logic       load_ready;
    logic       resp_valid;
    logic       resp_ready;
    logic [7:0] tx_byte;
    logic       tx_valid;
    logic       tx_ready;

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_parser u_parser (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .frame      (frame),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    // Write and execute side
    mlp_loader u_loader (
        .clk           (clk),
        .rst           (rst),
        .frame         (frame),
        .load_valid    (load_valid),
        .load_ready    (load_ready),
        .mlp_ctrl      (mlp_ctrl),
        .weights_ready (weights_ready)
    );

    // Read and status side
    resp_sender u_resp (
        .clk        (clk),
        .rst        (rst),
        .frame      (frame),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .mlp_status (mlp_status),
        .tx_byte    (tx_byte),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (uart_tx)
    );

endmodule

//--- sim.f
+incdir+common
+incdir+test
common/tpu_ctrl_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/cmd_parser.sv
rtl/mlp_loader.sv
rtl/resp_sender.sv
rtl/uart_controller.sv
test/tb_uart_controller.sv

//--- test/tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Host side serial frame, one bit per bit period, changed on falling edges
task automatic send_byte(input logic [7:0] data);
    logic [9:0] bits;
    int         i;
    bits = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
        @(negedge clk);
        rx_line = bits[i];
        repeat (`UART_CLKS_PER_BIT - 1) @(negedge clk);
    end
endtask

// Samples the DUT line near the middle of each bit
task automatic receive_byte(output logic [7:0] data, output logic framing_ok);
    int i;
    @(negedge tx_line);
    repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
    framing_ok = (tx_line === 1'b0);
    for (i = 0; i < 8; i++) begin
        repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        data[i] = tx_line;
    end
    repeat (`UART_CLKS_PER_BIT) @(negedge clk);
    framing_ok = framing_ok && (tx_line === 1'b1);
endtask

task automatic check_mlp_ctrl(input mlp_ctrl_t got, input mlp_ctrl_t exp, input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_resp_byte(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

//--- test/tb_uart_controller.sv
`include "tpu_ctrl_consts.svh"

module tb_uart_controller;

    import tpu_ctrl_pkg::*;

    localparam int NUM_CMDS        = 40;
    localparam int WATCHDOG_TIME   = NUM_CMDS * 15 * `UART_CLKS_PER_BIT * 10 * 100 + 200000;
    localparam int MAX_WAIT_CYCLES = 6 * 10 * `UART_CLKS_PER_BIT;

    // One predicted accelerator strobe cycle
    typedef struct packed {
        mlp_ctrl_t ctrl;
        logic      chain;
        logic      sets_ready;
    } exp_event_t;

    logic        clk;
    logic        rst;
    logic        rx_line;
    logic        tx_line;
    mlp_ctrl_t   mlp_ctrl;
    logic        weights_ready;
    mlp_status_t mlp_status;

    integer      seed;
    exp_event_t  exp_ctrl_q[$];
    logic [7:0]  exp_resp_q[$];
    logic        exp_wr;
    logic        prev_strobe;

    uart_controller UUT (
        .clk           (clk),
        .rst           (rst),
        .uart_rx       (rx_line),
        .uart_tx       (tx_line),
        .mlp_ctrl      (mlp_ctrl),
        .weights_ready (weights_ready),
        .mlp_status    (mlp_status)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Run stopped after an error");
    endtask

    `include "tb_uart_tasks.svh"

    // Fields that carry no data while their strobe is low are cleared
    function automatic mlp_ctrl_t mask_ctrl(input mlp_ctrl_t c);
        mlp_ctrl_t m;
        m = c;
        if (!(c.push_col0 || c.push_col1)) begin
            m.weight = '0;
        end
        if (!c.act_valid) begin
            m.act_row = '0;
        end
        return m;
    endfunction

    function automatic mlp_status_t random_status();
        mlp_status_t s;
        s.state     = $random(seed);
        s.cycle_cnt = $random(seed);
        s.acc0      = $random(seed);
        return s;
    endfunction

    // Expected strobes and response bytes for one command
    task automatic predict_command(input logic [7:0] op, input logic [3:0][7:0] payload,
                                   input mlp_status_t st);
        exp_event_t ev;
        int         i;
        case (op)
            OP_WRITE_WEIGHT: begin
                for (i = 0; i < 4; i++) begin
                    ev                = '0;
                    ev.ctrl.push_col0 = (i % 2 == 0);
                    ev.ctrl.push_col1 = (i % 2 == 1);
                    ev.ctrl.weight    = payload[i];
                    ev.chain          = (i != 0);
                    ev.sets_ready     = (i == 3);
                    exp_ctrl_q.push_back(ev);
                end
            end
            OP_WRITE_ACT: begin
                for (i = 0; i < 2; i++) begin
                    ev                = '0;
                    ev.ctrl.act_valid = 1'b1;
                    ev.ctrl.act_row   = {payload[2*i+1], payload[2*i]};
                    ev.chain          = (i != 0);
                    exp_ctrl_q.push_back(ev);
                end
            end
            OP_EXECUTE: begin
                ev            = '0;
                ev.ctrl.start = 1'b1;
                exp_ctrl_q.push_back(ev);
            end
            OP_READ_RESULT: begin
                for (i = 0; i < 4; i++) begin
                    exp_resp_q.push_back(st.acc0[8*i +: 8]);
                end
            end
            OP_STATUS: exp_resp_q.push_back({st.state[2:0], st.cycle_cnt});
            default: ;
        endcase
    endtask

    // Strobe monitor, sampled away from the rising edge
    always @(negedge clk) begin
        logic       strobe;
        exp_event_t head;
        if (rst === 1'b0) begin
            strobe = mlp_ctrl.push_col0 || mlp_ctrl.push_col1 || mlp_ctrl.act_valid
                     || mlp_ctrl.start;
            if (strobe) begin
                if (exp_ctrl_q.size() == 0) begin
                    $display("Unexpected accelerator strobe at time %0t", $time);
                    abort_run();
                end else begin
                    head = exp_ctrl_q.pop_front();
                    check_mlp_ctrl(mask_ctrl(mlp_ctrl), head.ctrl, "accelerator strobe");
                    if (head.sets_ready) begin
                        exp_wr = 1'b1;
                    end
                end
            end else if (exp_ctrl_q.size() != 0 && prev_strobe) begin
                head = exp_ctrl_q[0];
                if (head.chain) begin
                    check_flag(strobe, 1'b1, "strobe in the following cycle");
                end
            end
            check_flag(weights_ready, exp_wr, "weights_ready");
            prev_strobe = strobe;
        end
    end

    // Response monitor on the serial output
    initial begin
        logic [7:0] data;
        logic       framing_ok;
        wait (rst === 1'b0);
        forever begin
            receive_byte(data, framing_ok);
            if (!framing_ok) begin
                $display("Bad start or stop bit on the serial output at time %0t", $time);
                abort_run();
            end
            if (exp_resp_q.size() == 0) begin
                $display("Response byte %h arrived with none expected", data);
                abort_run();
            end
            check_resp_byte(data, exp_resp_q.pop_front(), "response byte");
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the commands did not complete within %0d time units",
                 WATCHDOG_TIME);
        abort_run();
    end

    initial begin
        int              n;
        int              i;
        int              pick;
        int              wait_cycles;
        logic [7:0]      op;
        logic [3:0][7:0] payload;
        clk         = 1'b0;
        rst         = 1'b1;
        rx_line     = 1'b1;
        mlp_status  = '0;
        seed        = 32'h225d;
        exp_wr      = 1'b0;
        prev_strobe = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);

        for (n = 0; n < NUM_CMDS; n++) begin
            mlp_status = random_status();
            pick       = {$random(seed)} % 6;
            payload    = $random(seed);
            if (pick == 0) begin
                // Any byte outside the opcode range
                op = $random(seed);
                if (op >= 8'd1 && op <= 8'd5) begin
                    op = op | 8'h80;
                end
            end else begin
                op = pick;
            end
            predict_command(op, payload, mlp_status);
            send_byte(op);
            if (op == OP_WRITE_WEIGHT || op == OP_WRITE_ACT) begin
                for (i = 0; i < 4; i++) begin
                    send_byte(payload[i]);
                end
            end
            // New status after the frame is taken must not reach the response
            repeat (2) @(negedge clk);
            mlp_status  = random_status();
            wait_cycles = 0;
            while ((exp_ctrl_q.size() != 0 || exp_resp_q.size() != 0)
                   && wait_cycles < MAX_WAIT_CYCLES) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (exp_ctrl_q.size() != 0 || exp_resp_q.size() != 0) begin
                $display("Command %0d: expected strobes or response bytes never appeared",
                         n);
                abort_run();
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        end

        repeat (4 * `UART_CLKS_PER_BIT) @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

//--- uart/uart_rx.sv
`include "tpu_ctrl_consts.svh"

module uart_rx #(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CW = $clog2(clks_per_bit);
    localparam logic [CW-1:0] HALF_LAST = CW'(clks_per_bit / 2 - 1);
    localparam logic [CW-1:0] BIT_LAST = CW'(clks_per_bit - 1);

    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;
    logic          busy;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [7:0]    shift;

    // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync) begin
                    busy    <= 1'b1;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (clk_cnt == ((bit_idx == 4'd0) ? HALF_LAST : BIT_LAST)) begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0) begin
                    // Line back high at mid start bit means a glitch
                    if (rx_sync) begin
                        busy <= 1'b0;
                    end
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_sync;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (busy && clk_cnt == BIT_LAST && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign rx_byte = shift;

endmodule

//--- uart/uart_tx.sv
`include "tpu_ctrl_consts.svh"

module uart_tx #(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);

    localparam int CW = $clog2(clks_per_bit);
    localparam logic [CW-1:0] BIT_LAST = CW'(clks_per_bit - 1);

    logic          busy;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [8:0]    shift;

    assign tx_ready = !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else if (!busy) begin
            if (tx_valid) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
                tx      <= 1'b0;
            end
        end else if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                // Stop bit done
                busy <= 1'b0;
            end else begin
                tx      <= shift[0];
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Data bits then the stop bit, shifted in behind with ones
    always_ff @(posedge clk) begin
        if (!busy && tx_valid) begin
            shift <= {1'b1, tx_byte};
        end else if (busy && clk_cnt == BIT_LAST) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    a_no_valid_while_busy: assert property (
        @(posedge clk) disable iff (rst) $rose(tx_valid) |-> !busy
    );

endmodule
